// ==== include/zports_defines.svh ====
// zports constants: port addresses, extended register numbers, reset values
`ifndef ZPORTS_DEFINES_SVH
`define ZPORTS_DEFINES_SVH

// low address byte of the decoded ports
`define ZP_PORT_FE      8'hFE   // keyboard and tape
`define ZP_PORT_XT      8'hAF   // extended registers, number in high byte
`define ZP_PORT_FD      8'hFD   // 7FFD family

// nemo IDE ports
`define ZP_IDE_10       8'h10   // data, low byte
`define ZP_IDE_11       8'h11   // data, high byte
`define ZP_IDE_30       8'h30
`define ZP_IDE_50       8'h50
`define ZP_IDE_70       8'h70
`define ZP_IDE_90       8'h90
`define ZP_IDE_B0       8'hB0
`define ZP_IDE_D0       8'hD0
`define ZP_IDE_F0       8'hF0
`define ZP_IDE_C8       8'hC8   // control block, cs1

// extended register numbers
`define ZP_XT_RAMPAGE   8'h10   // covers 10 to 13
`define ZP_XT_FMADDR    8'h15
`define ZP_XT_SYSCONF   8'h20
`define ZP_XT_MEMCONF   8'h21
`define ZP_XT_IM2VECT   8'h25

// reset values
`define ZP_RST_SYSCONF  8'h01   // 7 MHz turbo
`define ZP_RST_MEMCONF  8'h04   // no map
`define ZP_RST_IM2VECT  8'hFF
`define ZP_RST_PAGE0    8'h00
`define ZP_RST_PAGE1    8'h05
`define ZP_RST_PAGE2    8'h02
`define ZP_RST_PAGE3    8'h00

`define ZP_FMADDR_W     5

`endif

// ==== rtl/ide_data_path.sv ====
// IDE holding bytes, data pairing and IDE bus control signals
`timescale 1ns/1ps
`default_nettype none

`include "zports_defines.svh"

module ide_data_path
(
	input  logic                  zclk,
	input  logic [15:0]           a,
	input  zports_pkg::zbyte_t    din,
	input  zports_pkg::ide_word_t idein,
	input  logic                  iord,
	input  logic                  iowr,
	input  logic                  port_rd,
	input  logic                  port_wr,
	input  logic                  sel_ide10,
	input  logic                  sel_ide11,
	input  logic                  sel_ide_any,
	input  zports_pkg::ide_seq_t  cyc_state,
	output zports_pkg::ide_word_t ideout,
	output logic                  idedataout,
	output logic [2:0]            ide_a,
	output logic                  ide_cs0_n,
	output logic                  ide_cs1_n,
	output logic                  ide_rd_n,
	output logic                  ide_wr_n,
	output zports_pkg::zbyte_t    ide_rd_byte
);

	import zports_pkg::*;

	zbyte_t wr_hi;  // held high byte for writes
	zbyte_t wr_lo;  // held low byte for writes
	zbyte_t rd_hi;  // high half of the last word read
	logic   is_c8;

	always_ff @(posedge zclk)
	begin
		if (port_wr && sel_ide11)
			wr_hi <= din;
		if (port_wr && sel_ide10 && cyc_state != IDE_WR_LO)
			wr_lo <= din;
		if (port_rd && sel_ide10 && cyc_state != IDE_RD_HI)
			rd_hi <= idein[15:8];
	end

	assign is_c8     = (a[7:0] == `ZP_IDE_C8);
	assign ide_a     = a[7:5];
	assign ide_cs0_n = !(sel_ide_any && !is_c8);
	assign ide_cs1_n = !(sel_ide_any && is_c8);

	// second divide read comes from rd_hi, no device cycle
	assign ide_rd_n = !(iord && sel_ide_any && !(sel_ide10 && cyc_state == IDE_RD_HI));
	// first divide write only fills wr_lo
	assign ide_wr_n = !(iowr && sel_ide_any && !(sel_ide10 && cyc_state == IDE_IDLE));

	assign idedataout = !ide_wr_n;

	assign ideout[15:8] = (cyc_state == IDE_WR_HI) ? wr_hi : din;
	assign ideout[7:0]  = (cyc_state == IDE_WR_LO) ? wr_lo : din;

	assign ide_rd_byte = (sel_ide11 || (sel_ide10 && cyc_state == IDE_RD_HI)) ?
	                     rd_hi : idein[7:0];

endmodule

`default_nettype wire

// ==== rtl/ide_pair_fsm.sv ====
// state machine for the nemo-divide and normal ordering of IDE data bytes
`timescale 1ns/1ps
`default_nettype none

module ide_pair_fsm
(
	input  logic                 zclk,
	input  logic                 rst,
	input  logic                 iord,
	input  logic                 iowr,
	input  logic                 port_rd,
	input  logic                 port_wr,
	input  logic                 sel_ide10,
	input  logic                 sel_ide11,
	input  logic                 sel_ide_any,
	output zports_pkg::ide_seq_t cyc_state
);

	import zports_pkg::*;

	ide_seq_t state;
	ide_seq_t state_nx;
	logic     ide_hit;   // any IDE port, 11 included
	logic     ide_acc;   // strobe on an IDE port

	assign ide_hit = sel_ide_any || sel_ide11;
	assign ide_acc = ide_hit && (port_rd || port_wr);

	always_comb
	begin
		state_nx = state;
		if (ide_acc)
		begin
			if (port_wr && sel_ide11)
				state_nx = IDE_WR_HI;  // high byte of a normal write
			else if (state == IDE_IDLE && port_rd && sel_ide10)
				state_nx = IDE_RD_HI;  // high half now held
			else if (state == IDE_IDLE && port_wr && sel_ide10)
				state_nx = IDE_WR_LO;
			else
				state_nx = IDE_IDLE;   // pair completed or broken
		end
	end

	always_ff @(posedge zclk)
	begin
		if (rst)
			state <= IDE_IDLE;
		else
			state <= state_nx;
	end

	// sampled between accesses only, so an access sees the state
	// left by the previous one for its whole length
	always_ff @(posedge zclk)
	begin
		if (rst)
			cyc_state <= IDE_IDLE;
		else if (!iord && !iowr)
			cyc_state <= state;
	end

endmodule

`default_nettype wire

// ==== rtl/port_decode.sv ====
// I/O strobe generation and decode of the low address byte into port selects
`timescale 1ns/1ps
`default_nettype none

`include "zports_defines.svh"

module port_decode
(
	input  logic        zclk,
	input  logic        rst,
	input  logic [15:0] a,
	input  logic        iord,
	input  logic        iowr,
	output logic        port_rd,
	output logic        port_wr,
	output logic        sel_fe,
	output logic        sel_xt,
	output logic        sel_7ffd,
	output logic        sel_ide10,
	output logic        sel_ide11,
	output logic        sel_ide_any,
	output logic        porthit
);

	import zports_pkg::*;

	logic   iord_q;  // levels from the previous edge
	logic   iowr_q;
	zbyte_t loa;

	// one cycle strobe on a rising level
	always_ff @(posedge zclk)
	begin
		if (rst)
		begin
			iord_q  <= 1'b0;
			iowr_q  <= 1'b0;
			port_rd <= 1'b0;
			port_wr <= 1'b0;
		end
		else
		begin
			iord_q  <= iord;
			iowr_q  <= iowr;
			port_rd <= iord && !iord_q;
			port_wr <= iowr && !iowr_q;
		end
	end

	assign loa = a[7:0];

	assign sel_fe    = (loa == `ZP_PORT_FE);
	assign sel_xt    = (loa == `ZP_PORT_XT);
	assign sel_7ffd  = (loa == `ZP_PORT_FD) && !a[15];  // a15 high is the AY
	assign sel_ide10 = (loa == `ZP_IDE_10);
	assign sel_ide11 = (loa == `ZP_IDE_11);

	// task file ports, 11 is not among them
	assign sel_ide_any = (loa == `ZP_IDE_10) || (loa == `ZP_IDE_30) ||
	                     (loa == `ZP_IDE_50) || (loa == `ZP_IDE_70) ||
	                     (loa == `ZP_IDE_90) || (loa == `ZP_IDE_B0) ||
	                     (loa == `ZP_IDE_D0) || (loa == `ZP_IDE_F0) ||
	                     (loa == `ZP_IDE_C8);

	assign porthit = sel_fe || sel_xt || sel_7ffd || sel_ide10 ||
	                 sel_ide11 || sel_ide_any;

endmodule

`default_nettype wire

// ==== rtl/port_read_mux.sv ====
// selection of the byte the CPU reads and the data bus drive enable
`timescale 1ns/1ps
`default_nettype none

module port_read_mux
(
	input  logic               [15:0] a,
	input  logic                      iord,
	input  logic               [4:0]  keys_in,
	input  logic                      tape_read,
	input  zports_pkg::zbyte_t        xt_rdata,
	input  zports_pkg::zbyte_t        ide_rd_byte,
	input  logic                      porthit,
	input  logic                      sel_fe,
	input  logic                      sel_xt,
	input  logic                      sel_ide11,
	input  logic                      sel_ide_any,
	output zports_pkg::zbyte_t        dout,
	output logic                      dataout
);

	import zports_pkg::*;

	logic ide_rd;  // task file or odd data port

	// port 11 is the only odd IDE port
	assign ide_rd = sel_ide_any || (sel_ide11 && a[0]);

	always_comb
	begin
		if (sel_fe)
			dout = {1'b1, tape_read, 1'b0, keys_in};
		else if (sel_xt)
			dout = xt_rdata;
		else if (ide_rd)
			dout = ide_rd_byte;
		else
			dout = 8'hFF;  // open bus
	end

	// drive the Z80 bus only on our own ports
	assign dataout = porthit && iord;

endmodule

`default_nettype wire

// ==== rtl/xt_regs.sv ====
// memory and system configuration registers, 128K paging port and lock-48
`timescale 1ns/1ps
`default_nettype none

`include "zports_defines.svh"

module xt_regs
(
	input  logic                     zclk,
	input  logic                     rst,
	input  logic [15:0]              a,
	input  zports_pkg::zbyte_t       din,
	input  logic                     port_wr,
	input  logic                     sel_xt,
	input  logic                     sel_7ffd,
	output logic [31:0]              xt_page,
	output logic [`ZP_FMADDR_W-1:0]  fmaddr,
	output zports_pkg::zbyte_t       sysconf,
	output zports_pkg::zbyte_t       memconf,
	output zports_pkg::zbyte_t       im2vect,
	output zports_pkg::zbyte_t       xt_rdata
);

	import zports_pkg::*;

	zbyte_t page [0:3];  // RAM pages for windows 0 to 3
	zbyte_t hoa;         // register number on xxAF
	logic   lck48;       // 48K lock, blocks 7FFD
	logic   xt_wr;
	logic   p7ffd_wr;
	logic   hoa_page;

	assign hoa      = a[15:8];
	assign hoa_page = (hoa[7:2] == `ZP_XT_RAMPAGE >> 2);
	assign xt_wr    = port_wr && sel_xt;
	assign p7ffd_wr = port_wr && sel_7ffd && !lck48;

	always_ff @(posedge zclk)
	begin
		if (rst)
		begin
			page[0] <= `ZP_RST_PAGE0;
			page[1] <= `ZP_RST_PAGE1;
			page[2] <= `ZP_RST_PAGE2;
			page[3] <= `ZP_RST_PAGE3;
			fmaddr  <= '0;
			sysconf <= `ZP_RST_SYSCONF;
			memconf <= `ZP_RST_MEMCONF;
			im2vect <= `ZP_RST_IM2VECT;
			lck48   <= 1'b0;
		end
		else if (p7ffd_wr)
		begin
			// both high page bits always in use
			page[3]    <= {3'b000, din[7:6], din[2:0]};
			memconf[0] <= din[4];  // rom select
			lck48      <= din[5];
		end
		else if (xt_wr)
		begin
			if (hoa_page)
				page[hoa[1:0]] <= din;
			if (hoa == `ZP_XT_FMADDR)
				fmaddr <= din[`ZP_FMADDR_W-1:0];
			if (hoa == `ZP_XT_SYSCONF)
				sysconf <= din;
			if (hoa == `ZP_XT_MEMCONF)
				memconf <= din;
			if (hoa == `ZP_XT_IM2VECT)
				im2vect <= din;
		end
	end

	// page 3 in the top byte
	assign xt_page = {page[3], page[2], page[1], page[0]};

	// only the pages read back
	always_comb
	begin
		if (hoa_page)
			xt_rdata = page[hoa[1:0]];
		else
			xt_rdata = 8'hFF;
	end

endmodule

`default_nettype wire

// ==== rtl/zports_pkg.sv ====
// zports types: data byte, IDE word and IDE byte pairing states
`default_nettype none

package zports_pkg;

	// one byte of the Z80 data bus
	typedef logic [7:0] zbyte_t;

	// one word of the IDE data bus
	typedef logic [15:0] ide_word_t;

	// nemo-divide pairing of IDE data bytes
	typedef enum logic [1:0]
	{
		IDE_IDLE  = 2'd0,  // no half word pending
		IDE_RD_HI = 2'd1,  // divide read, high byte waits in holding reg
		IDE_WR_LO = 2'd2,  // divide write, low byte held
		IDE_WR_HI = 2'd3   // normal write, high byte held
	} ide_seq_t;

	// normal read:  10 low, 11 high
	// divide read:  10 low, 10 high
	// normal write: 11 high, 10 low
	// divide write: 10 low, 10 high

endpackage

`default_nettype wire

// ==== rtl/zports_top.sv ====
// Z80 I/O port block: decode, configuration registers and IDE bridge
`timescale 1ns/1ps
`default_nettype none

`include "zports_defines.svh"

module zports_top
(
	input  logic                     zclk,
	input  logic                     rst,
	input  logic [15:0]              a,
	input  zports_pkg::zbyte_t       din,
	input  logic                     iord,
	input  logic                     iowr,
	input  logic [4:0]               keys_in,
	input  logic                     tape_read,
	input  zports_pkg::ide_word_t    idein,
	output zports_pkg::zbyte_t       dout,
	output logic                     dataout,
	output logic                     porthit,
	output logic [31:0]              xt_page,
	output logic [`ZP_FMADDR_W-1:0]  fmaddr,
	output zports_pkg::zbyte_t       sysconf,
	output zports_pkg::zbyte_t       memconf,
	output zports_pkg::zbyte_t       im2vect,
	output zports_pkg::ide_word_t    ideout,
	output logic                     idedataout,
	output logic [2:0]               ide_a,
	output logic                     ide_cs0_n,
	output logic                     ide_cs1_n,
	output logic                     ide_rd_n,
	output logic                     ide_wr_n
);

	import zports_pkg::*;

	logic     port_rd;
	logic     port_wr;
	logic     sel_fe;
	logic     sel_xt;
	logic     sel_7ffd;
	logic     sel_ide10;
	logic     sel_ide11;
	logic     sel_ide_any;
	ide_seq_t cyc_state;   // pairing state seen by the current access
	zbyte_t   xt_rdata;
	zbyte_t   ide_rd_byte;

	port_decode u_decode (
		.zclk(zclk), .rst(rst), .a(a), .iord(iord), .iowr(iowr),
		.port_rd(port_rd), .port_wr(port_wr),
		.sel_fe(sel_fe), .sel_xt(sel_xt), .sel_7ffd(sel_7ffd),
		.sel_ide10(sel_ide10), .sel_ide11(sel_ide11), .sel_ide_any(sel_ide_any),
		.porthit(porthit)
	);

	xt_regs u_xt (
		.zclk(zclk), .rst(rst), .a(a), .din(din), .port_wr(port_wr),
		.sel_xt(sel_xt), .sel_7ffd(sel_7ffd),
		.xt_page(xt_page), .fmaddr(fmaddr), .sysconf(sysconf),
		.memconf(memconf), .im2vect(im2vect), .xt_rdata(xt_rdata)
	);

	ide_pair_fsm u_pair (
		.zclk(zclk), .rst(rst), .iord(iord), .iowr(iowr),
		.port_rd(port_rd), .port_wr(port_wr),
		.sel_ide10(sel_ide10), .sel_ide11(sel_ide11), .sel_ide_any(sel_ide_any),
		.cyc_state(cyc_state)
	);

	ide_data_path u_ide (
		.zclk(zclk), .a(a), .din(din), .idein(idein), .iord(iord), .iowr(iowr),
		.port_rd(port_rd), .port_wr(port_wr),
		.sel_ide10(sel_ide10), .sel_ide11(sel_ide11), .sel_ide_any(sel_ide_any),
		.cyc_state(cyc_state), .ideout(ideout), .idedataout(idedataout),
		.ide_a(ide_a), .ide_cs0_n(ide_cs0_n), .ide_cs1_n(ide_cs1_n),
		.ide_rd_n(ide_rd_n), .ide_wr_n(ide_wr_n), .ide_rd_byte(ide_rd_byte)
	);

	port_read_mux u_rdmux (
		.a(a), .iord(iord), .keys_in(keys_in), .tape_read(tape_read),
		.xt_rdata(xt_rdata), .ide_rd_byte(ide_rd_byte), .porthit(porthit),
		.sel_fe(sel_fe), .sel_xt(sel_xt), .sel_ide11(sel_ide11),
		.sel_ide_any(sel_ide_any), .dout(dout), .dataout(dataout)
	);

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
rtl/zports_pkg.sv
rtl/port_decode.sv
rtl/xt_regs.sv
rtl/ide_pair_fsm.sv
rtl/ide_data_path.sv
rtl/port_read_mux.sv
rtl/zports_top.sv
verification/zports_assertions.sv
verification/zports_tb.sv

// ==== verification/zports_assertions.sv ====
// concurrent checks on the I/O strobes, IDE strobes and bus drive enable
`timescale 1ns/1ps
`default_nettype none

module zports_assertions
(
	input logic zclk,
	input logic rst,
	input logic port_rd,
	input logic port_wr,
	input logic ide_rd_n,
	input logic ide_wr_n,
	input logic dataout
);

	ide_strobe_excl: assert property (@(posedge zclk) disable iff (rst) ide_rd_n || ide_wr_n)
		else $error("ide_rd_n and ide_wr_n low in the same cycle");

	rd_strobe_single: assert property (@(posedge zclk) disable iff (rst) port_rd |=> !port_rd)
		else $error("port_rd high for more than one cycle");

	wr_strobe_single: assert property (@(posedge zclk) disable iff (rst) port_wr |=> !port_wr)
		else $error("port_wr high for more than one cycle");

	// an IDE read cycle always hands its byte to the CPU
	ide_read_drives: assert property (@(posedge zclk) disable iff (rst) !ide_rd_n |-> dataout)
		else $error("IDE read cycle while the CPU data bus is not driven");

endmodule

bind zports_top zports_assertions u_assertions (.*);

`default_nettype wire

// ==== verification/zports_tb.sv ====
// testbench for the Z80 I/O port block: config registers, 7FFD paging, IDE pairing
`timescale 1ns/1ps
`default_nettype none

`include "zports_defines.svh"

module zports_tb;

	import zports_pkg::*;

	logic                    zclk = 1'b0;
	logic                    rst;
	logic [15:0]             a;
	zbyte_t                  din;
	logic                    iord;
	logic                    iowr;
	logic [4:0]              keys_in;
	logic                    tape_read;
	ide_word_t               idein;
	zbyte_t                  dout;
	logic                    dataout;
	logic                    porthit;
	logic [31:0]             xt_page;
	logic [`ZP_FMADDR_W-1:0] fmaddr;
	zbyte_t                  sysconf;
	zbyte_t                  memconf;
	zbyte_t                  im2vect;
	ide_word_t               ideout;
	logic                    idedataout;
	logic [2:0]              ide_a;
	logic                    ide_cs0_n;
	logic                    ide_cs1_n;
	logic                    ide_rd_n;
	logic                    ide_wr_n;

	// shadow of the DUT state
	zbyte_t                  sh_page [0:3];
	logic [`ZP_FMADDR_W-1:0] sh_fmaddr;
	zbyte_t                  sh_sysconf;
	zbyte_t                  sh_memconf;
	zbyte_t                  sh_im2vect;
	logic                    sh_lock;
	ide_seq_t                sh_seq;
	zbyte_t                  sh_wr_hi;
	zbyte_t                  sh_wr_lo;
	zbyte_t                  sh_rd_hi;
	logic                    exp_hit;     // side results of the last ref_model call
	logic                    exp_rd_n;
	logic                    exp_wr_n;
	logic                    exp_cs0_n;
	logic                    exp_cs1_n;
	ide_word_t               exp_ideout;

	logic [31:0]             got_q [$];   // results waiting for the comparing process
	logic [31:0]             exp_q [$];
	string                   msg_q [$];
	logic [31:0]             got_v;
	logic [31:0]             exp_v;
	string                   msg_v;
	logic [31:0]             lcg_state;

	// known numbers plus two unused ones
	zbyte_t xt_nums [0:9] = '{`ZP_XT_RAMPAGE, 8'h11, 8'h12, 8'h13, `ZP_XT_FMADDR,
		`ZP_XT_SYSCONF, `ZP_XT_MEMCONF, `ZP_XT_IM2VECT, 8'h14, 8'h30};

	zports_top UUT (.*);

	always #2 zclk = ~zclk;

	function automatic zbyte_t lcg_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];
	endfunction

	// expected read byte; also updates the shadow and the exp_* side results
	function automatic zbyte_t ref_model(input logic wr, input logic [15:0] addr,
		input zbyte_t data);
		zbyte_t lo;
		zbyte_t hi;
		logic   tf;      // task file: x10 to xF0 with low nibble 0, plus C8
		logic   is_pg;
		zbyte_t rd;
		lo      = addr[7:0];
		hi      = addr[15:8];
		tf      = (lo[4:0] == 5'h10) || (lo == `ZP_IDE_C8);
		is_pg   = (hi >= `ZP_XT_RAMPAGE) && (hi <= `ZP_XT_RAMPAGE + 8'd3);
		exp_hit = (lo == `ZP_PORT_FE) || (lo == `ZP_PORT_XT) || tf || (lo == `ZP_IDE_11) ||
		          ((lo == `ZP_PORT_FD) && !addr[15]);
		exp_rd_n = !(!wr && tf && !((lo == `ZP_IDE_10) && (sh_seq == IDE_RD_HI)));
		exp_wr_n = !(wr && tf && !((lo == `ZP_IDE_10) && (sh_seq == IDE_IDLE)));
		exp_cs0_n = !(tf && (lo != `ZP_IDE_C8));
		exp_cs1_n = (lo != `ZP_IDE_C8);
		exp_ideout = {(sh_seq == IDE_WR_HI) ? sh_wr_hi : data,
		              (sh_seq == IDE_WR_LO) ? sh_wr_lo : data};
		rd = 8'hFF;
		if (lo == `ZP_PORT_FE)
			rd = {1'b1, tape_read, 1'b0, keys_in};
		else if (lo == `ZP_PORT_XT && is_pg)
			rd = sh_page[hi[1:0]];
		else if (lo == `ZP_IDE_11 || (lo == `ZP_IDE_10 && sh_seq == IDE_RD_HI))
			rd = sh_rd_hi;
		else if (tf)
			rd = idein[7:0];
		if (wr && lo == `ZP_PORT_XT)
		begin
			if (is_pg)
				sh_page[hi[1:0]] = data;
			sh_fmaddr  = (hi == `ZP_XT_FMADDR)  ? data[`ZP_FMADDR_W-1:0] : sh_fmaddr;
			sh_sysconf = (hi == `ZP_XT_SYSCONF) ? data : sh_sysconf;
			sh_memconf = (hi == `ZP_XT_MEMCONF) ? data : sh_memconf;
			sh_im2vect = (hi == `ZP_XT_IM2VECT) ? data : sh_im2vect;
		end
		if (wr && lo == `ZP_PORT_FD && !addr[15] && !sh_lock)
		begin
			sh_page[3]    = {3'b000, data[7:6], data[2:0]};
			sh_memconf[0] = data[4];
			sh_lock       = data[5];
		end
		if (wr && lo == `ZP_IDE_11)
			sh_wr_hi = data;
		if (wr && lo == `ZP_IDE_10 && sh_seq != IDE_WR_LO)
			sh_wr_lo = data;
		if (!wr && lo == `ZP_IDE_10 && sh_seq != IDE_RD_HI)
			sh_rd_hi = idein[15:8];
		if (tf || lo == `ZP_IDE_11)
		begin
			if (wr && lo == `ZP_IDE_11)
				sh_seq = IDE_WR_HI;
			else if (sh_seq == IDE_IDLE && lo == `ZP_IDE_10)
				sh_seq = wr ? IDE_WR_LO : IDE_RD_HI;
			else
				sh_seq = IDE_IDLE;
		end
		return rd;
	endfunction

	function automatic void queue_check(input logic [31:0] got, input logic [31:0] exp,
		input string msg);
		got_q.push_back(got);
		exp_q.push_back(exp);
		msg_q.push_back(msg);
	endfunction

	// comparing process
	always @(posedge zclk)
	begin
		while (got_q.size() > 0)
		begin
			got_v = got_q.pop_front();
			exp_v = exp_q.pop_front();
			msg_v = msg_q.pop_front();
			assert (got_v === exp_v)
			else
			begin
				$display("[ERROR] %0d ns: %s, got %h, expected %h", $time, msg_v, got_v, exp_v);
				$display("Checks failed");
				$fatal(1, "stopped at the first mismatch");
			end
		end
	end

	task automatic apply_reset();
		rst = 1'b1;
		repeat (5) @(posedge zclk);
		#1;
		rst        = 1'b0;
		sh_page[0] = `ZP_RST_PAGE0;
		sh_page[1] = `ZP_RST_PAGE1;
		sh_page[2] = `ZP_RST_PAGE2;
		sh_page[3] = `ZP_RST_PAGE3;
		sh_fmaddr  = '0;
		sh_sysconf = `ZP_RST_SYSCONF;
		sh_memconf = `ZP_RST_MEMCONF;
		sh_im2vect = `ZP_RST_IM2VECT;
		sh_lock    = 1'b0;
		sh_seq     = IDE_IDLE;
	endtask

	// returns 2 ns after the edge that launched the strobe
	task automatic strobe_wait(input logic wr);
		int   n;
		logic seen;
		seen = 1'b0;
		for (n = 0; n < 8 && !seen; n++)
		begin
			@(posedge zclk);
			#2;
			seen = wr ? UUT.port_wr : UUT.port_rd;
		end
		if (!seen)
		begin
			$display("timeout, the DUT gave no I/O strobe within 8 cycles");
			$display("Checks failed");
			$fatal(1, "strobe timeout");
		end
	endtask

	// entered and left 1 ns after an edge; level high 4 cycles, low 2
	task automatic io_read(input logic [15:0] addr, output zbyte_t data, output logic de,
		output logic hit, output logic rd_n, output logic [5:0] ctl);
		a    = addr;
		iord = 1'b1;
		strobe_wait(1'b0);
		repeat (2) @(posedge zclk);
		#2;
		data = dout;
		de   = dataout;
		hit  = porthit;
		rd_n = ide_rd_n;
		ctl  = {idedataout, ide_a, ide_cs0_n, ide_cs1_n};
		@(posedge zclk);
		#1;
		iord = 1'b0;
		repeat (2) @(posedge zclk);
		#1;
	endtask

	task automatic io_write(input logic [15:0] addr, input zbyte_t data,
		output ide_word_t word, output logic wr_n, output logic hit,
		output logic [5:0] ctl);
		a    = addr;
		din  = data;
		iowr = 1'b1;
		strobe_wait(1'b1);
		repeat (2) @(posedge zclk);
		#2;
		word = ideout;
		wr_n = ide_wr_n;
		hit  = porthit;
		ctl  = {idedataout, ide_a, ide_cs0_n, ide_cs1_n};
		@(posedge zclk);
		#1;
		iowr = 1'b0;
		repeat (2) @(posedge zclk);
		#1;
	endtask

	task automatic read_and_check(input logic [15:0] addr);
		zbyte_t     exp;
		zbyte_t     got;
		logic       de;
		logic       hit;
		logic       rd_n;
		logic [5:0] ctl;
		exp = ref_model(1'b0, addr, 8'h00);
		io_read(addr, got, de, hit, rd_n, ctl);
		queue_check(got, exp, $sformatf("dout on read of %h", addr));
		queue_check(de, exp_hit, $sformatf("dataout on read of %h", addr));
		queue_check(hit, exp_hit, $sformatf("porthit on read of %h", addr));
		queue_check(rd_n, exp_rd_n, $sformatf("ide_rd_n on read of %h", addr));
		queue_check(ctl, {!exp_wr_n, addr[7:5], exp_cs0_n, exp_cs1_n},
			$sformatf("IDE control on read of %h", addr));
	endtask

	task automatic write_and_check(input logic [15:0] addr, input zbyte_t data);
		ide_word_t  exp_word;
		ide_word_t  word;
		logic       wr_n;
		logic       hit;
		logic [5:0] ctl;
		void'(ref_model(1'b1, addr, data));
		exp_word = exp_ideout;
		io_write(addr, data, word, wr_n, hit, ctl);
		queue_check(word, exp_word, $sformatf("ideout on write of %h to %h", data, addr));
		queue_check(wr_n, exp_wr_n, $sformatf("ide_wr_n on write to %h", addr));
		queue_check(hit, exp_hit, $sformatf("porthit on write to %h", addr));
		queue_check(ctl, {!exp_wr_n, addr[7:5], exp_cs0_n, exp_cs1_n},
			$sformatf("IDE control on write to %h", addr));
	endtask

	function automatic void check_regs();
		queue_check(xt_page, {sh_page[3], sh_page[2], sh_page[1], sh_page[0]}, "xt_page");
		queue_check(fmaddr, sh_fmaddr, "fmaddr");
		queue_check(sysconf, sh_sysconf, "sysconf");
		queue_check(memconf, sh_memconf, "memconf");
		queue_check(im2vect, sh_im2vect, "im2vect");
	endfunction

	initial
	begin
		int     i;
		zbyte_t r;
		lcg_state = 32'd61552;
		a         = '0;
		din       = '0;
		iord      = 1'b0;
		iowr      = 1'b0;
		keys_in   = '0;
		tape_read = 1'b0;
		idein     = '0;
		apply_reset();
		check_regs();
		for (i = 0; i < 4; i++)
		begin
			r = `ZP_XT_RAMPAGE + i;
			read_and_check({r, `ZP_PORT_XT});
		end

		// random xxAF writes, read back every number afterwards
		for (i = 0; i < 24; i++)
		begin
			r = lcg_byte();
			write_and_check({xt_nums[r % 10], `ZP_PORT_XT}, lcg_byte());
			check_regs();
		end
		for (i = 0; i < 10; i++)
			read_and_check({xt_nums[i], `ZP_PORT_XT});

		// 7FFD paging, then lock-48 until the next reset
		write_and_check(16'h7FFD, lcg_byte() & 8'hDF);
		check_regs();
		write_and_check(16'h7FFD, 8'h37);
		check_regs();
		write_and_check(16'h7FFD, lcg_byte());
		write_and_check(16'hFFFD, 8'hC7);   // a15 high is not 7FFD
		check_regs();
		apply_reset();
		write_and_check(16'h7FFD, 8'h53);
		check_regs();

		// divide read, then normal read 10 and 11
		idein = {lcg_byte(), lcg_byte()};
		read_and_check({8'h00, `ZP_IDE_10});
		idein = {lcg_byte(), lcg_byte()};
		read_and_check({8'h00, `ZP_IDE_10});
		idein = {lcg_byte(), lcg_byte()};
		read_and_check({8'h00, `ZP_IDE_10});
		read_and_check({8'h00, `ZP_IDE_11});
		read_and_check({8'h00, `ZP_IDE_F0});

		// divide write, normal write, control port
		write_and_check({8'h00, `ZP_IDE_10}, lcg_byte());
		write_and_check({8'h00, `ZP_IDE_10}, lcg_byte());
		write_and_check({8'h00, `ZP_IDE_11}, lcg_byte());
		write_and_check({8'h00, `ZP_IDE_10}, lcg_byte());
		write_and_check({8'h00, `ZP_IDE_C8}, lcg_byte());

		for (i = 0; i < 2; i++)
		begin
			r         = lcg_byte();
			keys_in   = r[4:0];
			tape_read = r[7];
			read_and_check({lcg_byte(), `ZP_PORT_FE});
		end
		read_and_check(16'h1234);   // nothing decodes these
		read_and_check(16'hFFFD);
		read_and_check(16'h00A0);

		repeat (2) @(posedge zclk);
		#1;
		if (got_q.size() == 0)
		begin
			$display("All checks passed");
			$finish;
		end
		else
		begin
			$display("results were left unchecked at the end of the run");
			$display("Checks failed");
			$fatal(1, "unchecked results");
		end
	end

endmodule

`default_nettype wire
